//--- hw/lsu_consts.svh
////////////////////////////////////////////////////////////
// load-store unit widths and access-fault cause codes
////////////////////////////////////////////////////////////

`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// bus and register file widths
`define LSU_DATA_W 32
`define LSU_ADDR_W 32
`define LSU_BE_W   4
`define LSU_RD_W   5

// mcause values reported on a bus error
`define LSU_CAUSE_LOAD_FAULT  6'd5
`define LSU_CAUSE_STORE_FAULT 6'd7

`endif

//--- hw/lsu_pkg.sv
////////////////////////////////////////////////////////////
// load-store unit types
// access FSM states, access sizes and fault causes
////////////////////////////////////////////////////////////

`include "lsu_consts.svh"

package lsu_pkg;

  // access FSM
  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT,
    WAIT_GNT_MIS,
    WAIT_RVALID_MIS,
    WAIT_RVALID_MIS_GNTS_DONE
  } lsu_state_e;

  // access size as encoded by the decoder
  typedef enum logic [1:0] {
    SIZE_WORD = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_BYTE = 2'b10
  } lsu_size_e;

  typedef enum logic [5:0] {
    NO_FAULT    = 6'd0,
    LOAD_FAULT  = `LSU_CAUSE_LOAD_FAULT,
    STORE_FAULT = `LSU_CAUSE_STORE_FAULT
  } lsu_cause_e;

endpackage

//--- hw/lsu_seq_if.sv
////////////////////////////////////////////////////////////
// sequencing strobes between the access FSM and the
// address and load datapaths
////////////////////////////////////////////////////////////

`include "lsu_consts.svh"

interface lsu_seq_if;

  // from the FSM
  logic                   go;
  logic                   handle_mis;
  logic                   addr_incr;
  logic                   addr_update;
  logic                   ctrl_update;
  logic                   rdata_update;

  // from the address datapath
  logic                   split;
  logic [`LSU_ADDR_W-1:0] addr_last;

  modport ctrl (
    output go, handle_mis, addr_incr, addr_update, ctrl_update, rdata_update,
    input  split, addr_last
  );

  modport dp (
    input  go, handle_mis, addr_incr, addr_update, ctrl_update, rdata_update,
    output split, addr_last
  );

endinterface

//--- hw/lsu_ctrl.sv
////////////////////////////////////////////////////////////
// access FSM of the load-store unit
// outstanding-response and error tracking, fault cause
// and fault address
////////////////////////////////////////////////////////////

`include "lsu_consts.svh"

module lsu_ctrl import lsu_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   lsu_req_i,
  input  logic                   lsu_we_i,
  input  logic                   ds_rdy_i,
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  input  logic                   data_err_i,
  output logic                   data_req_o,
  output logic                   lsu_req_done_o,
  output logic                   resp_valid_o,
  output logic                   resp_err_o,
  output lsu_cause_e             resp_cause_o,
  output logic [`LSU_ADDR_W-1:0] resp_mtval_o,
  output logic                   busy_o,
  output logic                   perf_load_o,
  output logic                   perf_store_o,
  lsu_seq_if.ctrl                seq
);

  lsu_state_e state_q, state_d;
  logic       handle_mis_q, handle_mis_d;
  logic       err_q, err_d;
  logic       we_q;
  logic       outstanding_q;
  logic       resp_wait;
  logic       any_err;

  //////////////////////////////////////////////////////////////
  // access FSM
  //////////////////////////////////////////////////////////////

  always_comb begin
    state_d          = state_q;
    handle_mis_d     = handle_mis_q;
    err_d            = err_q;
    data_req_o       = 1'b0;
    perf_load_o      = 1'b0;
    perf_store_o     = 1'b0;
    seq.go           = 1'b0;
    seq.addr_incr    = 1'b0;
    seq.addr_update  = 1'b0;
    seq.ctrl_update  = 1'b0;
    seq.rdata_update = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (lsu_req_i && !resp_wait && ds_rdy_i) begin
          data_req_o   = 1'b1;
          seq.go       = 1'b1;
          err_d        = 1'b0;
          perf_load_o  = ~lsu_we_i;
          perf_store_o = lsu_we_i;
          if (data_gnt_i) begin
            seq.ctrl_update = 1'b1;
            seq.addr_update = 1'b1;
            handle_mis_d    = seq.split;
            state_d         = seq.split ? WAIT_RVALID_MIS : IDLE;
          end else begin
            state_d = seq.split ? WAIT_GNT_MIS : WAIT_GNT;
          end
        end
      end

      WAIT_GNT_MIS: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          seq.addr_update = 1'b1;
          seq.ctrl_update = 1'b1;
          handle_mis_d    = 1'b1;
          state_d         = WAIT_RVALID_MIS;
        end
      end

      WAIT_RVALID_MIS: begin
        // second part is on the bus while the first response is pending
        data_req_o    = 1'b1;
        seq.addr_incr = 1'b1;
        if (data_rvalid_i) begin
          err_d            = data_err_i;
          seq.rdata_update = ~we_q;
          // keep the first failing address for mtval
          seq.addr_update  = data_gnt_i & ~data_err_i;
          handle_mis_d     = ~data_gnt_i;
          state_d          = data_gnt_i ? IDLE : WAIT_GNT;
        end else if (data_gnt_i) begin
          handle_mis_d = 1'b0;
          state_d      = WAIT_RVALID_MIS_GNTS_DONE;
        end
      end

      WAIT_GNT: begin
        data_req_o    = 1'b1;
        seq.addr_incr = handle_mis_q;
        if (data_gnt_i) begin
          seq.ctrl_update = 1'b1;
          seq.addr_update = ~err_q;
          handle_mis_d    = 1'b0;
          state_d         = IDLE;
        end
      end

      WAIT_RVALID_MIS_GNTS_DONE: begin
        // both parts granted, first response still due
        seq.addr_incr = 1'b1;
        if (data_rvalid_i) begin
          err_d            = data_err_i;
          seq.addr_update  = ~data_err_i;
          seq.rdata_update = ~we_q;
          state_d          = IDLE;
        end
      end

      default: state_d = IDLE;
    endcase
  end

  assign seq.handle_mis = handle_mis_q;

  // a response blocks new requests until delivered, and while it reports an error
  assign any_err   = err_q | data_err_i;
  assign resp_wait = outstanding_q & (~resp_valid_o | any_err);

  assign lsu_req_done_o = (seq.go | (state_q != IDLE)) & (state_d == IDLE);
  assign resp_valid_o   = data_rvalid_i & (state_q == IDLE);
  assign resp_err_o     = any_err & resp_valid_o;
  assign busy_o         = (state_q != IDLE);

  // fault cause from the write flag of the accepted request
  always_comb begin
    resp_cause_o = NO_FAULT;
    resp_mtval_o = '0;
    if (any_err) begin
      resp_cause_o = we_q ? STORE_FAULT : LOAD_FAULT;
      resp_mtval_o = seq.addr_last;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= IDLE;
      handle_mis_q  <= 1'b0;
      err_q         <= 1'b0;
      we_q          <= 1'b0;
      outstanding_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      handle_mis_q <= handle_mis_d;
      err_q        <= err_d;
      if (seq.go) begin
        we_q <= lsu_we_i;
      end
      if (seq.go) begin
        outstanding_q <= 1'b1;
      end else if (resp_valid_o) begin
        outstanding_q <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////
  // assertions
  //////////////////////////////////////////////////////////////

  a_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o && !data_gnt_i |=> data_req_o)
    else $error("data_req_o dropped before data_gnt_i");

  a_rvalid_expected: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_rvalid_i |-> outstanding_q)
    else $error("data_rvalid_i with no access outstanding");

  // the final response comes back in IDLE, with no second part left
  a_resp_in_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_o |-> !handle_mis_q)
    else $error("resp_valid_o while a second part is still pending");

endmodule

//--- hw/lsu_req_align.sv
////////////////////////////////////////////////////////////
// request side of the load-store unit
// bus address, split detection, byte enables, store data
// rotation and the last-address register
////////////////////////////////////////////////////////////

`include "lsu_consts.svh"

module lsu_req_align import lsu_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`LSU_ADDR_W-1:0] lsu_addr_i,
  input  lsu_size_e              lsu_size_i,
  input  logic [`LSU_DATA_W-1:0] lsu_wdata_i,
  output logic [`LSU_ADDR_W-1:0] data_addr_o,
  output logic [`LSU_BE_W-1:0]   data_be_o,
  output logic [`LSU_DATA_W-1:0] data_wdata_o,
  output logic [1:0]             offset_o,
  lsu_seq_if.dp                  seq
);

  logic [`LSU_ADDR_W-1:0]   data_addr;
  logic [`LSU_ADDR_W-1:0]   addr_aligned;
  logic [`LSU_ADDR_W-1:0]   addr_last_q;
  logic [1:0]               data_offset;
  logic [1:0]               offset_q;
  logic [2*`LSU_DATA_W-1:0] wdata_dbl;

  // second part is one word above the registered first-part address
  assign data_addr    = seq.addr_incr ? addr_last_q + `LSU_ADDR_W'(`LSU_BE_W) : lsu_addr_i;
  assign data_offset  = data_addr[1:0];
  assign addr_aligned = {data_addr[`LSU_ADDR_W-1:2], 2'b00};
  assign data_addr_o  = addr_aligned;

  assign seq.split = ((lsu_size_i == SIZE_WORD) && (data_offset != 2'b00)) ||
                     ((lsu_size_i == SIZE_HALF) && (data_offset == 2'b11));

  //////////////////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////////////////

  always_comb begin
    unique case (lsu_size_i)
      SIZE_WORD: begin
        if (!seq.handle_mis) begin
          data_be_o = 4'b1111 << data_offset;
        end else begin
          // lanes below the offset
          data_be_o = ~(4'b1111 << data_offset);
        end
      end
      SIZE_HALF: begin
        data_be_o = seq.handle_mis ? 4'b0001 : 4'b0011 << data_offset;
      end
      default: data_be_o = 4'b0001 << data_offset;
    endcase
  end

  // store data rotated left into its lanes
  assign wdata_dbl    = {lsu_wdata_i, lsu_wdata_i} << {data_offset, 3'b000};
  assign data_wdata_o = wdata_dbl[2*`LSU_DATA_W-1 -: `LSU_DATA_W];

  //////////////////////////////////////////////////////////////
  // last address and offset
  //////////////////////////////////////////////////////////////

  // mtval holds the byte address, or the aligned second-part address
  always_ff @(posedge clk_i) begin
    if (seq.addr_update) begin
      addr_last_q <= seq.addr_incr ? addr_aligned : data_addr;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q <= 2'b00;
    end else if (seq.ctrl_update) begin
      offset_q <= data_offset;
    end
  end

  assign seq.addr_last = addr_last_q;
  assign offset_o      = offset_q;

  a_be_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (seq.go || seq.handle_mis) |-> (data_be_o != '0))
    else $error("data_be_o is zero while a request is driven");

endmodule

//--- hw/lsu_load_align.sv
////////////////////////////////////////////////////////////
// load side of the load-store unit
// request attributes, first-part data, realignment and
// zero or sign extension
////////////////////////////////////////////////////////////

`include "lsu_consts.svh"

module lsu_load_align import lsu_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  lsu_size_e              lsu_size_i,
  input  logic                   lsu_sign_ext_i,
  input  logic [`LSU_RD_W-1:0]   lsu_rd_i,
  input  logic [1:0]             offset_i,
  input  logic [`LSU_DATA_W-1:0] data_rdata_i,
  output logic [`LSU_DATA_W-1:0] resp_rdata_o,
  output logic [`LSU_RD_W-1:0]   resp_rd_o,
  lsu_seq_if.dp                  seq
);

  lsu_size_e                size_q;
  logic                     sign_ext_q;
  logic [`LSU_RD_W-1:0]     rd_q;
  logic [`LSU_DATA_W-1:8]   rdata_q;
  logic                     split_q;
  logic [2*`LSU_DATA_W-1:0] window;
  logic [2*`LSU_DATA_W-1:0] shifted;
  logic [`LSU_DATA_W-1:0]   rdata_raw;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      size_q     <= SIZE_WORD;
      sign_ext_q <= 1'b0;
      rd_q       <= '0;
    end else if (seq.go) begin
      size_q     <= lsu_size_i;
      sign_ext_q <= lsu_sign_ext_i;
      rd_q       <= lsu_rd_i;
    end
  end

  // lane 0 of the first part never reaches the result
  always_ff @(posedge clk_i) begin
    if (seq.rdata_update) begin
      rdata_q <= data_rdata_i[`LSU_DATA_W-1:8];
    end
  end

  //////////////////////////////////////////////////////////////
  // realignment
  //////////////////////////////////////////////////////////////

  assign split_q = ((size_q == SIZE_WORD) && (offset_i != 2'b00)) ||
                   ((size_q == SIZE_HALF) && (offset_i == 2'b11));

  // a split access joins the held first-part bytes below the current word
  assign window    = split_q ? {data_rdata_i, rdata_q, 8'h00} :
                               {{`LSU_DATA_W{1'b0}}, data_rdata_i};
  assign shifted   = window >> {offset_i, 3'b000};
  assign rdata_raw = shifted[`LSU_DATA_W-1:0];

  // zero or sign extension
  always_comb begin
    unique case (size_q)
      SIZE_WORD: resp_rdata_o = rdata_raw;
      SIZE_HALF: begin
        resp_rdata_o = {{16{sign_ext_q & rdata_raw[15]}}, rdata_raw[15:0]};
      end
      default: begin
        resp_rdata_o = {{24{sign_ext_q & rdata_raw[7]}}, rdata_raw[7:0]};
      end
    endcase
  end

  assign resp_rd_o = rd_q;

endmodule

//--- hw/lsu_top.sv
////////////////////////////////////////////////////////////
// load-store unit top level
// access FSM, request datapath and load datapath
////////////////////////////////////////////////////////////

`include "lsu_consts.svh"

module lsu_top import lsu_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // pipeline request
  input  logic                   lsu_req_i,
  input  logic                   lsu_we_i,
  input  lsu_size_e              lsu_size_i,
  input  logic                   lsu_sign_ext_i,
  input  logic [`LSU_ADDR_W-1:0] lsu_addr_i,
  input  logic [`LSU_DATA_W-1:0] lsu_wdata_i,
  input  logic [`LSU_RD_W-1:0]   lsu_rd_i,
  input  logic                   ds_rdy_i,
  // data bus
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  input  logic                   data_err_i,
  input  logic [`LSU_DATA_W-1:0] data_rdata_i,
  output logic                   data_req_o,
  output logic [`LSU_ADDR_W-1:0] data_addr_o,
  output logic                   data_we_o,
  output logic [`LSU_BE_W-1:0]   data_be_o,
  output logic [`LSU_DATA_W-1:0] data_wdata_o,
  // pipeline response
  output logic                   lsu_req_done_o,
  output logic                   resp_valid_o,
  output logic                   resp_err_o,
  output logic [`LSU_DATA_W-1:0] resp_rdata_o,
  output logic [`LSU_RD_W-1:0]   resp_rd_o,
  output lsu_cause_e             resp_cause_o,
  output logic [`LSU_ADDR_W-1:0] resp_mtval_o,
  // status
  output logic                   busy_o,
  output logic                   perf_load_o,
  output logic                   perf_store_o
);

  logic [1:0] offset;

  lsu_seq_if seq_if ();

  assign data_we_o = lsu_we_i;

  lsu_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .lsu_req_i      (lsu_req_i),
    .lsu_we_i       (lsu_we_i),
    .ds_rdy_i       (ds_rdy_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_err_i     (data_err_i),
    .data_req_o     (data_req_o),
    .lsu_req_done_o (lsu_req_done_o),
    .resp_valid_o   (resp_valid_o),
    .resp_err_o     (resp_err_o),
    .resp_cause_o   (resp_cause_o),
    .resp_mtval_o   (resp_mtval_o),
    .busy_o         (busy_o),
    .perf_load_o    (perf_load_o),
    .perf_store_o   (perf_store_o),
    .seq            (seq_if.ctrl)
  );

  lsu_req_align u_req_align (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .lsu_addr_i   (lsu_addr_i),
    .lsu_size_i   (lsu_size_i),
    .lsu_wdata_i  (lsu_wdata_i),
    .data_addr_o  (data_addr_o),
    .data_be_o    (data_be_o),
    .data_wdata_o (data_wdata_o),
    .offset_o     (offset),
    .seq          (seq_if.dp)
  );

  lsu_load_align u_load_align (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .lsu_size_i     (lsu_size_i),
    .lsu_sign_ext_i (lsu_sign_ext_i),
    .lsu_rd_i       (lsu_rd_i),
    .offset_i       (offset),
    .data_rdata_i   (data_rdata_i),
    .resp_rdata_o   (resp_rdata_o),
    .resp_rd_o      (resp_rd_o),
    .seq            (seq_if.dp)
  );

endmodule

//--- verification/tb_lsu.sv
////////////////////////////////////////////////////////////
// testbench of the load-store unit
// bus memory model with random latency and error word,
// byte-level scoreboard, directed and random stimulus
////////////////////////////////////////////////////////////

`include "lsu_consts.svh"

module tb_lsu import lsu_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [7:0] ERR_WIDX = 8'hc0;  // byte address 0x300
  localparam int         TMO      = 200;

  typedef struct packed {
    logic        we;
    logic        err;
    logic [31:0] data;
    logic [31:0] mtval;
    logic [4:0]  rd;
  } exp_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [3:0]  be;
    logic [31:0] wdata;
  } bus_acc_t;

  typedef struct packed {
    logic [31:0] due;
    logic        err;
    logic [31:0] rdata;
  } rsp_t;

  logic clk_i, rst_ni;
  logic lsu_req_i, lsu_we_i, lsu_sign_ext_i, ds_rdy_i;
  lsu_size_e lsu_size_i;
  logic [31:0] lsu_addr_i, lsu_wdata_i;
  logic [4:0]  lsu_rd_i;
  logic data_gnt_i, data_rvalid_i, data_err_i;
  logic [31:0] data_rdata_i;
  logic data_req_o, data_we_o;
  logic [31:0] data_addr_o, data_wdata_o;
  logic [3:0]  data_be_o;
  logic lsu_req_done_o, resp_valid_o, resp_err_o, busy_o, perf_load_o, perf_store_o;
  logic [31:0] resp_rdata_o, resp_mtval_o;
  logic [4:0]  resp_rd_o;
  lsu_cause_e  resp_cause_o;

  logic [31:0] mem [0:255];
  logic [7:0]  ref_mem [0:1023];
  exp_t        exp_q[$];
  bus_acc_t    acc_log[$];
  rsp_t        rsp_q[$];
  integer      seed;
  int          errors;
  logic [31:0] cyc;
  logic [4:0]  rd_ctr;
  int          n_load;
  int          n_store;
  int          perf_load_cnt;
  int          perf_store_cnt;

  lsu_top uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////
  // bus memory model
  //////////////////////////////////////////////////////////////

  initial begin : bus_model
    int gnt_cnt;
    int d;
    logic [31:0] due;
    logic [31:0] last_due;
    logic [7:0] widx;
    logic is_err;
    rsp_t r;
    data_gnt_i = 1'b0;
    data_rvalid_i = 1'b0;
    data_err_i = 1'b0;
    data_rdata_i = '0;
    gnt_cnt = 1;
    last_due = '0;
    cyc = '0;
    forever begin
      @(posedge clk_i);
      cyc = cyc + 1;
      data_rvalid_i <= 1'b0;
      if (rst_ni) begin
        if (data_req_o && data_gnt_i) begin
          widx = data_addr_o[9:2];
          is_err = (widx == ERR_WIDX);
          r.rdata = mem[widx];
          r.err = is_err;
          if (data_we_o && !is_err) begin
            for (int l = 0; l < 4; l++) begin
              if (data_be_o[l]) mem[widx][8*l +: 8] = data_wdata_o[8*l +: 8];
            end
          end
          acc_log.push_back({data_addr_o, data_be_o, data_wdata_o});
          due = cyc + 32'(($random(seed) & 32'h3) % 3 + 1);
          if (due <= last_due) due = last_due + 1;
          last_due = due;
          r.due = due;
          rsp_q.push_back(r);
          d = $random(seed) & 32'h3;
          gnt_cnt = d;
          data_gnt_i <= (d == 0);
        end else if (data_req_o && gnt_cnt > 0) begin
          gnt_cnt = gnt_cnt - 1;
          if (gnt_cnt == 0) data_gnt_i <= 1'b1;
        end
        if (rsp_q.size() > 0 && rsp_q[0].due == cyc) begin
          r = rsp_q.pop_front();
          data_rvalid_i <= 1'b1;
          data_err_i    <= r.err;
          data_rdata_i  <= r.rdata;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////

  a_stalled_no_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!ds_rdy_i && !busy_o) |-> !data_req_o)
    else begin
      errors++;
      $display("** Error data_req_o: %h while ds_rdy_i is low", data_req_o);
    end

  a_addr_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o |-> (data_addr_o[1:0] == 2'b00))
    else begin
      errors++;
      $display("** Error data_addr_o: %h is not word-aligned", data_addr_o);
    end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("** Error %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("tests failed");
    $finish;
  endtask

  // response monitor in the middle of the cycle
  always @(negedge clk_i) begin
    exp_t e;
    if (rst_ni && perf_load_o) perf_load_cnt++;
    if (rst_ni && perf_store_o) perf_store_cnt++;
    if (rst_ni && resp_valid_o) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("response arrived with no request outstanding");
      end else begin
        e = exp_q.pop_front();
        check_val("resp_err_o", 32'(resp_err_o), 32'(e.err));
        check_val("resp_rd_o", 32'(resp_rd_o), 32'(e.rd));
        if (e.err) begin
          check_val("resp_cause_o", 32'(resp_cause_o),
                    e.we ? 32'(`LSU_CAUSE_STORE_FAULT) : 32'(`LSU_CAUSE_LOAD_FAULT));
          check_val("resp_mtval_o", resp_mtval_o, e.mtval);
        end else if (!e.we) begin
          check_val("resp_rdata_o", resp_rdata_o, e.data);
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////

  task automatic issue(input logic we, input lsu_size_e size, input logic sext,
                       input logic [31:0] addr, input logic [31:0] wdata);
    exp_t e;
    int a;
    int nb;
    int n;
    logic [7:0] b [0:3];
    logic split;
    a = int'(addr[9:0]);
    nb = (size == SIZE_WORD) ? 4 : (size == SIZE_HALF) ? 2 : 1;
    split = (int'(addr[1:0]) + nb) > 4;
    for (int i = 0; i < 4; i++) b[i] = ref_mem[(a + i) & 1023];
    case (size)
      SIZE_WORD: e.data = {b[3], b[2], b[1], b[0]};
      SIZE_HALF: e.data = {{16{sext & b[1][7]}}, b[1], b[0]};
      default:   e.data = {{24{sext & b[0][7]}}, b[0]};
    endcase
    e.we = we;
    e.err = (addr[9:2] == ERR_WIDX) || (split && (addr[9:2] + 8'd1 == ERR_WIDX));
    e.mtval = (addr[9:2] == ERR_WIDX) ? addr : {addr[31:2] + 30'd1, 2'b00};
    e.rd = rd_ctr;
    if (we) begin
      n_store++;
      for (int i = 0; i < nb; i++) ref_mem[(a + i) & 1023] = wdata[8*i +: 8];
    end else begin
      n_load++;
    end
    @(posedge clk_i);
    lsu_req_i      <= 1'b1;
    lsu_we_i       <= we;
    lsu_size_i     <= size;
    lsu_sign_ext_i <= sext;
    lsu_addr_i     <= addr;
    lsu_wdata_i    <= wdata;
    lsu_rd_i       <= rd_ctr;
    rd_ctr = rd_ctr + 5'd1;
    exp_q.push_back(e);
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
      if (n > TMO) abort_on_timeout("lsu_req_done_o");
    end while (!lsu_req_done_o);
  endtask

  // drop the request and let every response return
  task automatic drain;
    int n;
    @(posedge clk_i);
    lsu_req_i <= 1'b0;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
      if (n > TMO) abort_on_timeout("outstanding responses");
    end while (exp_q.size() != 0 || busy_o);
  endtask

  task automatic compare_memory;
    for (int w = 0; w < 256; w++) begin
      if (w != int'(ERR_WIDX)) begin
        check_val("memory word", mem[w],
                  {ref_mem[4*w+3], ref_mem[4*w+2], ref_mem[4*w+1], ref_mem[4*w]});
      end
    end
  endtask

  initial begin : main
    logic [31:0] addr;
    logic [31:0] w;
    logic [3:0]  be_exp;
    seed = 61;
    errors = 0;
    n_load = 0;
    n_store = 0;
    perf_load_cnt = 0;
    perf_store_cnt = 0;
    rd_ctr = '0;
    rst_ni = 1'b0;
    lsu_req_i = 1'b0;
    lsu_we_i = 1'b0;
    lsu_size_i = SIZE_WORD;
    lsu_sign_ext_i = 1'b0;
    lsu_addr_i = '0;
    lsu_wdata_i = '0;
    lsu_rd_i = '0;
    ds_rdy_i = 1'b1;
    for (int i = 0; i < 256; i++) begin
      mem[i] = (32'(i) * 32'h9e3779b1) ^ {24'h0, 8'(i)};
      for (int l = 0; l < 4; l++) ref_mem[4*i+l] = mem[i][8*l +: 8];
    end
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    // reset state and stall
    @(negedge clk_i);
    check_val("data_req_o", 32'(data_req_o), 32'h0);
    check_val("resp_valid_o", 32'(resp_valid_o), 32'h0);
    check_val("busy_o", 32'(busy_o), 32'h0);
    @(posedge clk_i);
    ds_rdy_i  <= 1'b0;
    lsu_req_i <= 1'b1;
    repeat (6) @(posedge clk_i);
    lsu_req_i <= 1'b0;
    @(posedge clk_i);
    ds_rdy_i <= 1'b1;

    // aligned word store and load
    addr = $random(seed) & 32'h1fc;
    w = $random(seed);
    acc_log.delete();
    issue(1'b1, SIZE_WORD, 1'b0, addr, w);
    drain();
    check_val("bus access count", 32'(acc_log.size()), 32'd1);
    if (acc_log.size() == 1) begin
      check_val("data_addr_o", acc_log[0].addr, addr);
      check_val("data_be_o", 32'(acc_log[0].be), 32'hf);
      check_val("data_wdata_o", acc_log[0].wdata, w);
    end
    issue(1'b0, SIZE_WORD, 1'b0, addr, '0);
    drain();

    // misaligned word stores
    for (int off = 1; off < 4; off++) begin
      addr = 32'h80 + 32'(off) + 32'(16 * off);
      w = $random(seed);
      acc_log.delete();
      issue(1'b1, SIZE_WORD, 1'b0, addr, w);
      drain();
      check_val("bus access count", 32'(acc_log.size()), 32'd2);
      if (acc_log.size() == 2) begin
        for (int l = 0; l < 4; l++) be_exp[l] = (l >= off);
        check_val("data_addr_o", acc_log[0].addr, {addr[31:2], 2'b00});
        check_val("data_addr_o", acc_log[1].addr, {addr[31:2], 2'b00} + 32'd4);
        check_val("data_be_o", 32'(acc_log[0].be), 32'(be_exp));
        check_val("data_be_o", 32'(acc_log[1].be), 32'(be_exp ^ 4'hf));
      end
      compare_memory();
      issue(1'b0, SIZE_WORD, 1'b0, addr, '0);
      drain();
    end

    // half-word and byte loads at every offset
    issue(1'b1, SIZE_WORD, 1'b0, 32'h100, 32'h8a7fc391);
    issue(1'b1, SIZE_WORD, 1'b0, 32'h104, 32'h81ff8042);
    drain();
    for (int off = 0; off < 4; off++) begin
      for (int s = 0; s < 2; s++) begin
        acc_log.delete();
        issue(1'b0, SIZE_HALF, s[0], 32'h100 + 32'(off), '0);
        drain();
        check_val("bus access count", 32'(acc_log.size()), (off == 3) ? 32'd2 : 32'd1);
        issue(1'b0, SIZE_BYTE, s[0], 32'h100 + 32'(off), '0);
        drain();
      end
    end

    // bus errors on the error word
    issue(1'b0, SIZE_WORD, 1'b0, 32'h300, '0);
    issue(1'b1, SIZE_WORD, 1'b0, 32'h300, 32'h12345678);
    issue(1'b0, SIZE_WORD, 1'b0, 32'h2fe, '0);
    issue(1'b1, SIZE_WORD, 1'b0, 32'h301, 32'hcafef00d);
    issue(1'b0, SIZE_HALF, 1'b1, 32'h2ff, '0);
    drain();

    // random back-to-back traffic
    for (int i = 0; i < 80; i++) begin
      issue(1'($random(seed)), lsu_size_e'(($random(seed) & 32'h7fff) % 3),
            1'($random(seed)), $random(seed) & 32'h1ff, $random(seed));
    end
    drain();

    // one performance pulse per accepted request
    check_val("perf_load_o count", 32'(perf_load_cnt), 32'(n_load));
    check_val("perf_store_o count", 32'(perf_store_cnt), 32'(n_store));

    $display("summary: %0d check errors, %0d responses missing", errors, exp_q.size());
    if (errors == 0 && exp_q.size() == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+hw
hw/lsu_pkg.sv
hw/lsu_seq_if.sv
hw/lsu_ctrl.sv
hw/lsu_req_align.sv
hw/lsu_load_align.sv
hw/lsu_top.sv
verification/tb_lsu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the load-store unit testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_lsu -f project.f -o tb_lsu
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out="$(./obj_dir/tb_lsu)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1
